/* common/mem_pkg.sv */
// Memory subsystem shared definitions: data word, byte address views, cache geometry
package mem_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and geometry
   ////////////////////////////////////////////////////////////

   // Data word and byte address
   localparam int WORD_BITS = 16;
   localparam int ADDR_BITS = 16;

   // Address split seen by a cache
   localparam int TAG_BITS = 8;
   localparam int INDEX_BITS = 4;
   localparam int WSEL_BITS = 3;

   // 16 lines of 8 words
   localparam int NUM_LINES = 1 << INDEX_BITS;
   localparam int WORDS_PER_LINE = 1 << WSEL_BITS;

   // Cycles from an accepted read to data_valid
   localparam int MEM_READ_LATENCY = 4;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////

   typedef logic [WORD_BITS-1:0] word_t;

   // Cache view of a byte address, tag at the top
   typedef struct packed {
      logic [TAG_BITS-1:0]   tag;
      logic [INDEX_BITS-1:0] index;
      logic [WSEL_BITS-1:0]  word_sel;
      // Byte within word, never decoded
      logic                  byte_sel;
   } mem_addr_fields_t;

   // Memory and arbiter use flat, caches use fields
   typedef union packed {
      logic [ADDR_BITS-1:0] flat;
      mem_addr_fields_t     fields;
   } mem_addr_u;

endpackage

/* hw/main_memory.sv */
// Main memory: single-cycle write, read data returned through a four-stage pipeline
`timescale 1ns/10ps

module main_memory #(
   parameter int MEM_ADDR_BITS = 15
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,
   input  logic               wr,
   input  mem_pkg::mem_addr_u addr,
   input  mem_pkg::word_t     data_in,
   output mem_pkg::word_t     data_out,
   output logic               data_valid
);

   localparam int DEPTH = 2 ** MEM_ADDR_BITS;
   localparam int LAT = mem_pkg::MEM_READ_LATENCY;

   // Word storage
   mem_pkg::word_t mem [DEPTH];

   // Word address, byte bit dropped
   logic [MEM_ADDR_BITS-1:0] word_addr;
   logic                     rd_issue;
   mem_pkg::word_t           rd_word;

   // Read return pipeline, last stage drives the outputs
   mem_pkg::word_t data_pipe [LAT];
   logic [LAT-1:0] valid_pipe;

   assign word_addr = addr.flat[MEM_ADDR_BITS:1];

   // Contents start cleared
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Access
   ////////////////////////////////////////////////////////////

   // Read lookup is combinational, launched into stage 0
   assign rd_issue = enable & ~wr;
   assign rd_word = rd_issue ? mem[word_addr] : '0;

   // Write lands at the edge
   always @(posedge clk) begin
      if (enable && wr) begin
         mem[word_addr] <= data_in;
      end
   end

   // Four stages, one per cycle of read latency
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
         for (int s = 0; s < LAT; s++) begin
            data_pipe[s] <= '0;
         end
      end else begin
         valid_pipe <= {valid_pipe[LAT-2:0], rd_issue};
         data_pipe[0] <= rd_word;
         for (int s = 1; s < LAT; s++) begin
            data_pipe[s] <= data_pipe[s-1];
         end
      end
   end

   assign data_out = data_pipe[LAT-1];
   assign data_valid = valid_pipe[LAT-1];

endmodule

/* cache/cache_array.sv */
// Cache array: tag, valid and data storage for one direct-mapped cache
`timescale 1ns/10ps

module cache_array (
   input  logic               clk,
   input  logic               rst,
   input  mem_pkg::mem_addr_u rd_addr,
   input  logic               wr_en,
   input  mem_pkg::mem_addr_u wr_addr,
   input  mem_pkg::word_t     wr_data,
   input  logic               set_valid,
   output mem_pkg::word_t     rd_data,
   output logic               hit
);

   localparam int SLOT_BITS = mem_pkg::INDEX_BITS + mem_pkg::WSEL_BITS;
   localparam int NUM_WORDS = mem_pkg::NUM_LINES * mem_pkg::WORDS_PER_LINE;

   // One tag and valid bit per line
   logic [mem_pkg::TAG_BITS-1:0] tag_mem [mem_pkg::NUM_LINES];
   logic [mem_pkg::NUM_LINES-1:0] valid;

   // All words of all lines, line-major
   mem_pkg::word_t data_mem [NUM_WORDS];

   logic [mem_pkg::INDEX_BITS-1:0] rd_line;
   logic [mem_pkg::INDEX_BITS-1:0] wr_line;
   logic [SLOT_BITS-1:0]           rd_slot;
   logic [SLOT_BITS-1:0]           wr_slot;

   assign rd_line = rd_addr.fields.index;
   assign wr_line = wr_addr.fields.index;
   assign rd_slot = {rd_addr.fields.index, rd_addr.fields.word_sel};
   assign wr_slot = {wr_addr.fields.index, wr_addr.fields.word_sel};

   ////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////

   // Word read and hit are both combinational
   assign rd_data = data_mem[rd_slot];
   assign hit = valid[rd_line] && (tag_mem[rd_line] == rd_addr.fields.tag);

   ////////////////////////////////////////////////////////////
   // Update
   ////////////////////////////////////////////////////////////

   // One word per cycle, refill return or store hit
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[wr_slot] <= wr_data;
      end
   end

   // Tag captured as the line completes
   always_ff @(posedge clk) begin
      if (set_valid) begin
         tag_mem[wr_line] <= wr_addr.fields.tag;
      end
   end

   // All lines invalid out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (set_valid) begin
         valid[wr_line] <= 1'b1;
      end
   end

endmodule

/* cache/cache_ctrl.sv */
// Cache controller: hit check, line refill FSM and write-through for one cache
`timescale 1ns/10ps

module cache_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               req,
   input  logic               wr,
   input  mem_pkg::mem_addr_u addr,
   input  mem_pkg::word_t     wdata,
   input  logic               mem_gnt,
   input  logic               mem_rvalid,
   input  mem_pkg::word_t     mem_rdata,
   output mem_pkg::word_t     rdata,
   output logic               done,
   output logic               mem_req,
   output logic               mem_wr,
   output mem_pkg::mem_addr_u mem_addr,
   output mem_pkg::word_t     mem_wdata
);

   // FSM states
   localparam logic [2:0] IDLE         = 3'd0;
   localparam logic [2:0] LOOKUP       = 3'd1;
   localparam logic [2:0] WRITE_THRU   = 3'd2;
   localparam logic [2:0] REFILL_ISSUE = 3'd3;
   localparam logic [2:0] REFILL_WAIT  = 3'd4;
   localparam logic [2:0] RESPOND      = 3'd5;

   // Counters run 0 to 8, one bit above the word select
   localparam int CNT_BITS = mem_pkg::WSEL_BITS + 1;
   localparam logic [CNT_BITS-1:0] LAST_WORD = CNT_BITS'(mem_pkg::WORDS_PER_LINE - 1);
   localparam logic [CNT_BITS-1:0] MAX_IN_FLIGHT = CNT_BITS'(mem_pkg::MEM_READ_LATENCY);

   logic [2:0]          state;
   logic [2:0]          state_next;
   logic [CNT_BITS-1:0] issue_cnt;
   logic [CNT_BITS-1:0] ret_cnt;
   logic [CNT_BITS-1:0] in_flight;
   logic                can_issue;
   logic                issue;
   logic                refilling;
   logic                ret_word;
   logic                last_ret;

   // Array side
   mem_pkg::mem_addr_u arr_wr_addr;
   mem_pkg::word_t     arr_wr_data;
   mem_pkg::word_t     arr_rd_data;
   logic               arr_wr_en;
   logic               arr_hit;
   logic               set_valid;

   // Requested word held for the respond cycle
   mem_pkg::word_t resp_word;

   cache_array array_inst (
      .clk       (clk),
      .rst       (rst),
      .rd_addr   (addr),
      .wr_en     (arr_wr_en),
      .wr_addr   (arr_wr_addr),
      .wr_data   (arr_wr_data),
      .set_valid (set_valid),
      .rd_data   (arr_rd_data),
      .hit       (arr_hit)
   );

   ////////////////////////////////////////////////////////////
   // Refill bookkeeping
   ////////////////////////////////////////////////////////////

   // Reads out but not yet back
   assign in_flight = issue_cnt - ret_cnt;
   // A return in this cycle frees a slot
   assign can_issue = (in_flight < MAX_IN_FLIGHT) || mem_rvalid;

   assign refilling = (state == REFILL_ISSUE) || (state == REFILL_WAIT);
   assign issue = (state == REFILL_ISSUE) && can_issue && mem_gnt;
   // Returns arrive in issue order
   assign ret_word = refilling && mem_rvalid;
   assign last_ret = ret_word && (ret_cnt == LAST_WORD);

   ////////////////////////////////////////////////////////////
   // Memory port
   ////////////////////////////////////////////////////////////

   // Request only in cycles that would issue
   assign mem_req = (state == WRITE_THRU) || ((state == REFILL_ISSUE) && can_issue);
   assign mem_wr = (state == WRITE_THRU);
   assign mem_wdata = wdata;

   // Refill walks the line from word 0
   always_comb begin
      mem_addr = addr;
      if (state == REFILL_ISSUE) begin
         mem_addr.fields.word_sel = issue_cnt[mem_pkg::WSEL_BITS-1:0];
         mem_addr.fields.byte_sel = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Array updates
   ////////////////////////////////////////////////////////////

   // Refill word at the return offset, otherwise store data
   always_comb begin
      arr_wr_addr = addr;
      arr_wr_data = wdata;
      if (refilling) begin
         arr_wr_addr.fields.word_sel = ret_cnt[mem_pkg::WSEL_BITS-1:0];
         arr_wr_data = mem_rdata;
      end
   end

   // Store updates only a line already present
   assign arr_wr_en = ret_word || ((state == WRITE_THRU) && mem_gnt && arr_hit);
   // Tag and valid with the eighth word
   assign set_valid = last_ret;

   ////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (req) begin
               state_next = LOOKUP;
            end
         end
         LOOKUP: begin
            if (wr) begin
               state_next = WRITE_THRU;
            end else if (arr_hit) begin
               state_next = IDLE;
            end else begin
               state_next = REFILL_ISSUE;
            end
         end
         WRITE_THRU: begin
            if (mem_gnt) begin
               state_next = RESPOND;
            end
         end
         REFILL_ISSUE: begin
            // Last word out, wait for the tail returns
            if (issue && (issue_cnt == LAST_WORD)) begin
               state_next = REFILL_WAIT;
            end
         end
         REFILL_WAIT: begin
            if (last_ret) begin
               state_next = RESPOND;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // Counters cleared on every lookup
   always_ff @(posedge clk) begin
      if (rst || (state == LOOKUP)) begin
         issue_cnt <= '0;
         ret_cnt <= '0;
      end else begin
         if (issue) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (ret_word) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   // Catch the requested word as it passes
   always_ff @(posedge clk) begin
      if (ret_word && (ret_cnt[mem_pkg::WSEL_BITS-1:0] == addr.fields.word_sel)) begin
         resp_word <= mem_rdata;
      end
   end

   // Read hit answers straight from the array during lookup
   assign done = ((state == LOOKUP) && !wr && arr_hit) || (state == RESPOND);
   assign rdata = (state == RESPOND) ? resp_word : arr_rd_data;

endmodule

/* hw/mem_arbiter.sv */
// Memory arbiter: fixed-priority owner of the shared memory port, data cache first
`timescale 1ns/10ps

module mem_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  logic               d_req,
   input  logic               d_wr,
   input  mem_pkg::mem_addr_u d_addr,
   input  mem_pkg::word_t     d_wdata,
   input  logic               i_req,
   input  logic               i_wr,
   input  mem_pkg::mem_addr_u i_addr,
   input  mem_pkg::word_t     i_wdata,
   input  mem_pkg::word_t     data_out,
   input  logic               data_valid,
   output logic               d_gnt,
   output logic               i_gnt,
   output logic               d_rvalid,
   output logic               i_rvalid,
   output mem_pkg::word_t     rdata,
   output logic               enable,
   output logic               wr,
   output mem_pkg::mem_addr_u addr,
   output mem_pkg::word_t     data_in
);

   // Room for a full pipeline plus one issue
   localparam int PEND_BITS = $clog2(mem_pkg::MEM_READ_LATENCY + 2);

   // Registered owner, at most one set
   logic d_own;
   logic i_own;

   // Reads accepted by memory and not yet returned
   logic [PEND_BITS-1:0] pending;
   logic [PEND_BITS-1:0] pending_next;
   logic                 rd_issue;
   logic                 busy_next;

   ////////////////////////////////////////////////////////////
   // Grant and port mux
   ////////////////////////////////////////////////////////////

   // Free port goes to data first
   assign d_gnt = d_own | (~i_own & d_req);
   assign i_gnt = i_own | (~d_own & ~d_req & i_req);

   // No owner, no access
   assign enable = (d_gnt & d_req) | (i_gnt & i_req);
   assign wr = d_gnt ? d_wr : i_wr;
   assign addr = d_gnt ? d_addr : i_addr;
   assign data_in = d_gnt ? d_wdata : i_wdata;

   ////////////////////////////////////////////////////////////
   // Ownership
   ////////////////////////////////////////////////////////////

   assign rd_issue = enable & ~wr;

   always_comb begin
      pending_next = pending;
      if (rd_issue) begin
         pending_next = pending_next + 1'b1;
      end
      if (data_valid) begin
         pending_next = pending_next - 1'b1;
      end
   end

   // Returns still owed keep the owner in place
   assign busy_next = (pending_next != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         d_own <= 1'b0;
         i_own <= 1'b0;
         pending <= '0;
      end else begin
         d_own <= d_gnt & (d_req | busy_next);
         i_own <= i_gnt & (i_req | busy_next);
         pending <= pending_next;
      end
   end

   // Read returns steered to the owner only
   assign d_rvalid = d_own & data_valid;
   assign i_rvalid = i_own & data_valid;
   assign rdata = data_out;

endmodule

/* hw/mem_system.sv */
// Memory system top: instruction and data caches sharing one main memory
`timescale 1ns/10ps

module mem_system #(
   parameter int MEM_ADDR_BITS = 15
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               i_req,
   input  mem_pkg::mem_addr_u i_addr,
   input  logic               d_req,
   input  logic               d_wr,
   input  mem_pkg::mem_addr_u d_addr,
   input  mem_pkg::word_t     d_wdata,
   output mem_pkg::word_t     i_rdata,
   output logic               i_done,
   output mem_pkg::word_t     d_rdata,
   output logic               d_done
);

   // Instruction cache to arbiter
   logic               i_mem_req;
   logic               i_mem_wr;
   mem_pkg::mem_addr_u i_mem_addr;
   mem_pkg::word_t     i_mem_wdata;
   logic               i_gnt;
   logic               i_rvalid;

   // Data cache to arbiter
   logic               d_mem_req;
   logic               d_mem_wr;
   mem_pkg::mem_addr_u d_mem_addr;
   mem_pkg::word_t     d_mem_wdata;
   logic               d_gnt;
   logic               d_rvalid;

   // Shared return data
   mem_pkg::word_t     mem_rdata;

   // Arbiter to memory
   logic               enable;
   logic               wr;
   mem_pkg::mem_addr_u addr;
   mem_pkg::word_t     data_in;
   mem_pkg::word_t     data_out;
   logic               data_valid;

   // Fetch path never stores
   cache_ctrl i_cache (
      .clk        (clk),
      .rst        (rst),
      .req        (i_req),
      .wr         (1'b0),
      .addr       (i_addr),
      .wdata      ('0),
      .mem_gnt    (i_gnt),
      .mem_rvalid (i_rvalid),
      .mem_rdata  (mem_rdata),
      .rdata      (i_rdata),
      .done       (i_done),
      .mem_req    (i_mem_req),
      .mem_wr     (i_mem_wr),
      .mem_addr   (i_mem_addr),
      .mem_wdata  (i_mem_wdata)
   );

   cache_ctrl d_cache (
      .clk        (clk),
      .rst        (rst),
      .req        (d_req),
      .wr         (d_wr),
      .addr       (d_addr),
      .wdata      (d_wdata),
      .mem_gnt    (d_gnt),
      .mem_rvalid (d_rvalid),
      .mem_rdata  (mem_rdata),
      .rdata      (d_rdata),
      .done       (d_done),
      .mem_req    (d_mem_req),
      .mem_wr     (d_mem_wr),
      .mem_addr   (d_mem_addr),
      .mem_wdata  (d_mem_wdata)
   );

   mem_arbiter arbiter_inst (
      .clk        (clk),
      .rst        (rst),
      .d_req      (d_mem_req),
      .d_wr       (d_mem_wr),
      .d_addr     (d_mem_addr),
      .d_wdata    (d_mem_wdata),
      .i_req      (i_mem_req),
      .i_wr       (i_mem_wr),
      .i_addr     (i_mem_addr),
      .i_wdata    (i_mem_wdata),
      .data_out   (data_out),
      .data_valid (data_valid),
      .d_gnt      (d_gnt),
      .i_gnt      (i_gnt),
      .d_rvalid   (d_rvalid),
      .i_rvalid   (i_rvalid),
      .rdata      (mem_rdata),
      .enable     (enable),
      .wr         (wr),
      .addr       (addr),
      .data_in    (data_in)
   );

   main_memory #(
      .MEM_ADDR_BITS (MEM_ADDR_BITS)
   ) memory_inst (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .wr         (wr),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .data_valid (data_valid)
   );

endmodule

/* verif/mem_system_checker.sv */
// Memory system checker: scores each cache completion for read data and hit latency
`timescale 1ns/10ps

module mem_system_checker (
   input  logic             clk,
   input  logic             rst,
   input  logic             d_req,
   input  logic             d_done,
   input  mem_pkg::word_t   d_rdata,
   input  logic [8*24-1:0]  d_name,
   input  logic [7:0]       d_op,
   input  mem_pkg::word_t   d_exp,
   input  logic             i_req,
   input  logic             i_done,
   input  mem_pkg::word_t   i_rdata,
   input  logic [8*24-1:0]  i_name,
   input  logic [7:0]       i_op,
   input  mem_pkg::word_t   i_exp,
   output int               pass_count,
   output int               fail_count
);

   // Read hit: done in the cycle after req is first seen
   localparam int HIT_CYCLES = 1;

   // Edges with req high and no done yet
   int d_wait;
   int i_wait;

   task automatic score_completion(input logic [8*24-1:0] name, input logic [7:0] port,
                                   input logic [7:0] op, input mem_pkg::word_t exp,
                                   input mem_pkg::word_t got, input int cycles);
      logic ok;
      ok = 1'b1;
      // Stores return no data
      if ((op != "W") && (got !== exp)) begin
         ok = 1'b0;
         $display("CHECK FAILED %0s port %c: expected %h actual %h", name, port, exp, got);
      end
      if ((op == "H") && (cycles != HIT_CYCLES)) begin
         ok = 1'b0;
         $display("CHECK FAILED %0s port %c hit latency: expected %0d actual %0d",
                  name, port, HIT_CYCLES, cycles);
      end
      if (ok) begin
         pass_count++;
         $display("ok %0s port %c op %c data %h after %0d cycles", name, port, op, got, cycles);
      end else begin
         fail_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sampling at the clock edge
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (rst) begin
         d_wait = 0;
         i_wait = 0;
         pass_count = 0;
         fail_count = 0;
      end else begin
         if (d_done) begin
            score_completion(d_name, "D", d_op, d_exp, d_rdata, d_wait);
            d_wait = 0;
         end else if (d_req) begin
            d_wait++;
         end
         if (i_done) begin
            score_completion(i_name, "I", i_op, i_exp, i_rdata, i_wait);
            i_wait = 0;
         end else if (i_req) begin
            i_wait++;
         end
      end
   end

endmodule

/* verif/mem_system_tb.sv */
// Memory system testbench: clock, reset, test table reader and request driver
`timescale 1ns/10ps

module mem_system_tb;

   localparam int MAX_TESTS = 64;
   localparam int DONE_TIMEOUT = 200;
   localparam int NAME_BITS = 8 * 24;

   logic               clk;
   logic               rst;
   logic               i_req;
   mem_pkg::mem_addr_u i_addr;
   logic               d_req;
   logic               d_wr;
   mem_pkg::mem_addr_u d_addr;
   mem_pkg::word_t     d_wdata;
   mem_pkg::word_t     i_rdata;
   logic               i_done;
   mem_pkg::word_t     d_rdata;
   logic               d_done;

   // Test in progress per port, for the checker
   logic [NAME_BITS-1:0] d_name;
   logic [7:0]           d_op;
   mem_pkg::word_t       d_exp;
   logic [NAME_BITS-1:0] i_name;
   logic [7:0]           i_op;
   mem_pkg::word_t       i_exp;

   int pass_count;
   int fail_count;

   // Test table, one entry per file line
   logic [NAME_BITS-1:0] t_name [MAX_TESTS];
   logic [7:0]           t_port [MAX_TESTS];
   logic [7:0]           t_op [MAX_TESTS];
   logic [15:0]          t_addr [MAX_TESTS];
   mem_pkg::word_t       t_wdata [MAX_TESTS];
   mem_pkg::word_t       t_exp [MAX_TESTS];
   int                   num_tests;

   // Set on any failure outside the checker
   logic bad_run;

   mem_system #(
      .MEM_ADDR_BITS (15)
   ) mem_system_inst (
      .clk     (clk),
      .rst     (rst),
      .i_req   (i_req),
      .i_addr  (i_addr),
      .d_req   (d_req),
      .d_wr    (d_wr),
      .d_addr  (d_addr),
      .d_wdata (d_wdata),
      .i_rdata (i_rdata),
      .i_done  (i_done),
      .d_rdata (d_rdata),
      .d_done  (d_done)
   );

   mem_system_checker checker_inst (
      .clk        (clk),
      .rst        (rst),
      .d_req      (d_req),
      .d_done     (d_done),
      .d_rdata    (d_rdata),
      .d_name     (d_name),
      .d_op       (d_op),
      .d_exp      (d_exp),
      .i_req      (i_req),
      .i_done     (i_done),
      .i_rdata    (i_rdata),
      .i_name     (i_name),
      .i_op       (i_op),
      .i_exp      (i_exp),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic load_tests();
      int                   fd;
      int                   code;
      logic [8*120-1:0]     line_buf;
      logic [NAME_BITS-1:0] name;
      logic [7:0]           port;
      logic [7:0]           op;
      logic [15:0]          addr;
      logic [15:0]          wdata;
      logic [15:0]          exp;
      num_tests = 0;
      fd = $fopen("verif/mem_system_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test file verif/mem_system_tests.txt");
         bad_run = 1'b1;
      end else begin
         while (!$feof(fd) && (num_tests < MAX_TESTS)) begin
            line_buf = '0;
            code = $fgets(line_buf, fd);
            code = $sscanf(line_buf, "%s %s %s %h %h %h", name, port, op, addr, wdata, exp);
            // Comment and blank lines give fewer fields
            if (code == 6) begin
               t_name[num_tests] = name;
               t_port[num_tests] = port;
               t_op[num_tests] = op;
               t_addr[num_tests] = addr;
               t_wdata[num_tests] = wdata;
               t_exp[num_tests] = exp;
               num_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Raise one port's request from table entry k
   task automatic drive_port(input int k);
      if (t_port[k] == "D") begin
         d_req = 1'b1;
         d_wr = (t_op[k] == "W");
         d_addr.flat = t_addr[k];
         d_wdata = t_wdata[k];
         d_name = t_name[k];
         d_op = t_op[k];
         d_exp = t_exp[k];
      end else begin
         i_req = 1'b1;
         i_addr.flat = t_addr[k];
         i_name = t_name[k];
         i_op = t_op[k];
         i_exp = t_exp[k];
      end
   endtask

   // Returns 1 ns after the edge that showed the last done
   task automatic wait_done(input logic want_d, input logic want_i, output logic ok);
      int   cycles;
      logic d_seen;
      logic i_seen;
      logic d_now;
      logic i_now;
      cycles = 0;
      d_seen = !want_d;
      i_seen = !want_i;
      while (!(d_seen && i_seen) && (cycles < DONE_TIMEOUT)) begin
         @(posedge clk);
         cycles++;
         d_now = !d_seen && d_done;
         i_now = !i_seen && i_done;
         d_seen = d_seen || d_now;
         i_seen = i_seen || i_now;
         // Drop req before IDLE can see it again
         #1;
         if (d_now) begin
            d_req = 1'b0;
         end
         if (i_now) begin
            i_req = 1'b0;
         end
      end
      ok = d_seen && i_seen;
      if (!d_seen) begin
         $display("Data port gave no done within %0d cycles in test %0s", DONE_TIMEOUT, d_name);
      end
      if (!i_seen) begin
         $display("Instruction port gave no done within %0d cycles in test %0s",
                  DONE_TIMEOUT, i_name);
      end
      if (!ok) begin
         d_req = 1'b0;
         i_req = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int   k;
      logic is_pair;
      logic want_d;
      logic want_i;
      logic ok;
      bad_run = 1'b0;
      rst = 1'b1;
      i_req = 1'b0;
      i_addr = '0;
      d_req = 1'b0;
      d_wr = 1'b0;
      d_addr = '0;
      d_wdata = '0;
      d_name = '0;
      d_op = "R";
      d_exp = '0;
      i_name = '0;
      i_op = "R";
      i_exp = '0;
      load_tests();
      if (!bad_run && (num_tests == 0)) begin
         $display("No tests found in verif/mem_system_tests.txt");
         bad_run = 1'b1;
      end
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      k = 0;
      while ((k < num_tests) && !bad_run) begin
         // Two lines under one name go out together
         is_pair = ((k + 1) < num_tests) && (t_name[k+1] == t_name[k]);
         want_d = (t_port[k] == "D") || (is_pair && (t_port[k+1] == "D"));
         want_i = (t_port[k] == "I") || (is_pair && (t_port[k+1] == "I"));
         drive_port(k);
         if (is_pair) begin
            drive_port(k + 1);
         end
         wait_done(want_d, want_i, ok);
         if (!ok) begin
            bad_run = 1'b1;
         end
         k += is_pair ? 2 : 1;
      end
      // Let the checker score the last completion
      repeat (2) @(posedge clk);
      if (!bad_run && ((pass_count + fail_count) != num_tests)) begin
         $display("Checker saw %0d completions for %0d tests", pass_count + fail_count,
                  num_tests);
         bad_run = 1'b1;
      end
      $display("Tests finished: %0d passed, %0d failed, %0d in file", pass_count, fail_count,
               num_tests);
      if (bad_run || (fail_count != 0)) begin
         $display("Checks failed");
      end else begin
         $display("All checks passed");
      end
      $finish;
   end

endmodule

/* verif/mem_system_tests.txt */
# Columns: name port op address wdata expected, all values hex
# port I or D, op W store, R read, H read that must hit
# Two lines with one name are a pair, driven in the same cycle
# Reset state reads zero
rst_zero_d        D R 0040 0000 0000
rst_zero_i        I R 0100 0000 0000
# Store, refill, then line hits
line_store        D W 0206 1234 0000
line_fill         D R 0206 0000 1234
line_hit_a        D H 020a 0000 0000
line_hit_b        D H 0206 0000 1234
# Store hit updates the cached word
store_hit_w       D W 020a beef 0000
store_hit_r       D H 020a 0000 beef
# Same index, two tags, each miss replaces
alias_store_a     D W 1230 aaaa 0000
alias_store_b     D W 4530 5555 0000
alias_read_a1     D R 1230 0000 aaaa
alias_read_b1     D R 4530 0000 5555
alias_read_a2     D R 1230 0000 aaaa
alias_store_miss  D W 4532 7777 0000
alias_keep        D H 1232 0000 0000
alias_read_b2     D R 4532 0000 7777
# Instruction fetch sees stored word
xport_store       D W 0480 c0de 0000
xport_fetch       I R 0480 0000 c0de
# Both ports miss together
pair_setup_a      D W 0800 1111 0000
pair_setup_b      D W 0c02 2222 0000
pair_miss         D R 0800 0000 1111
pair_miss         I R 0c02 0000 2222
pair_mixed        D W 0a04 3333 0000
pair_mixed        I R 0800 0000 1111
pair_hit          D R 0a04 0000 3333
pair_hit          I H 0800 0000 1111

/* flist.f */
common/mem_pkg.sv
hw/main_memory.sv
cache/cache_array.sv
cache/cache_ctrl.sv
hw/mem_arbiter.sv
hw/mem_system.sv
verif/mem_system_checker.sv
verif/mem_system_tb.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  # Shared package first
  - common/mem_pkg.sv
  # Design
  - hw/main_memory.sv
  - cache/cache_array.sv
  - cache/cache_ctrl.sv
  - hw/mem_arbiter.sv
  - hw/mem_system.sv
  # Verification
  - target: test
    files:
      - verif/mem_system_checker.sv
      - verif/mem_system_tb.sv
